//--- source/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data and address width
`define EXU_XLEN 32

// register file index
`define EXU_REG_AW 5

`define EXU_CSR_AW 12      // full csr address space

// zimm field of csrrwi/csrrsi/csrrci
`define EXU_ZIMM_W 5

`define EXU_INST_BYTES 4   // no compressed instructions

`endif

//--- source/exu_pkg.sv
package exu_pkg;

  // instruction class, picks operands and write rules
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_BRANCH = 4'd5,
    EXC_LOAD   = 4'd6,
    EXC_STORE  = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9,
    EXC_CSR    = 4'd10
  } exc_op_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // same codes as funct3 of the branch opcode
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd4,
    BR_GE  = 3'd5,
    BR_LTU = 3'd6,
    BR_GEU = 3'd7
  } br_cond_e;

  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,
    CSR_RW   = 2'd1,
    CSR_RS   = 2'd2,
    CSR_RC   = 2'd3
  } csr_op_e;

endpackage

//--- source/exu_alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0]   pc_i,
  input  logic [`EXU_XLEN-1:0]   rs1_data_i,
  input  logic [`EXU_XLEN-1:0]   rs2_data_i,
  input  logic [`EXU_XLEN-1:0]   imm_i,
  input  exu_pkg::exc_op_e       exc_op_i,
  input  exu_pkg::alu_op_e       alu_op_i,
  input  exu_pkg::csr_op_e       csr_op_i,
  input  logic [`EXU_XLEN-1:0]   csr_data_i,
  input  logic                   csr_use_imm_i,
  input  logic [`EXU_ZIMM_W-1:0] csr_zimm_i,
  output logic [`EXU_XLEN-1:0]   alu_result_o,
  output logic [`EXU_XLEN-1:0]   csr_wdata_o
);

  localparam int SHW = $clog2(`EXU_XLEN);

  logic [`EXU_XLEN-1:0] op_a;
  logic [`EXU_XLEN-1:0] op_b;
  exu_pkg::alu_op_e     op_sel;
  logic [SHW-1:0]       shamt;
  logic [`EXU_XLEN-1:0] csr_src;

  // operand select, only the OP classes honour the decoded function
  always_comb begin
    op_a   = '0;
    op_b   = '0;
    op_sel = exu_pkg::ALU_ADD;
    case (exc_op_i)
      exu_pkg::EXC_OPREG: begin
        op_a   = rs1_data_i;
        op_b   = rs2_data_i;
        op_sel = alu_op_i;
      end
      exu_pkg::EXC_OPIMM: begin
        op_a   = rs1_data_i;
        op_b   = imm_i;
        op_sel = alu_op_i;
      end
      exu_pkg::EXC_LOAD, exu_pkg::EXC_STORE: begin
        op_a = rs1_data_i;   // effective address
        op_b = imm_i;
      end
      exu_pkg::EXC_LUI:   op_b = imm_i;
      exu_pkg::EXC_AUIPC: begin
        op_a = pc_i;
        op_b = imm_i;
      end
      exu_pkg::EXC_JAL, exu_pkg::EXC_JALR: begin
        op_a = pc_i;         // link address
        op_b = `EXU_XLEN'(`EXU_INST_BYTES);
      end
      exu_pkg::EXC_CSR:   op_b = csr_data_i;  // old value goes to rd
      default: ;
    endcase
  end

  assign shamt = op_b[SHW-1:0];

  always_comb begin
    case (op_sel)
      exu_pkg::ALU_ADD:  alu_result_o = op_a + op_b;
      exu_pkg::ALU_SUB:  alu_result_o = op_a - op_b;
      exu_pkg::ALU_SLL:  alu_result_o = op_a << shamt;
      exu_pkg::ALU_SLT:  alu_result_o = `EXU_XLEN'($signed(op_a) < $signed(op_b));
      exu_pkg::ALU_SLTU: alu_result_o = `EXU_XLEN'(op_a < op_b);
      exu_pkg::ALU_XOR:  alu_result_o = op_a ^ op_b;
      exu_pkg::ALU_SRL:  alu_result_o = op_a >> shamt;
      exu_pkg::ALU_SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
      exu_pkg::ALU_OR:   alu_result_o = op_a | op_b;
      exu_pkg::ALU_AND:  alu_result_o = op_a & op_b;
      default:           alu_result_o = '0;
    endcase
  end

  // csr write value, source is rs1 or zero-extended zimm
  assign csr_src = csr_use_imm_i ? `EXU_XLEN'(csr_zimm_i) : rs1_data_i;

  always_comb begin
    case (csr_op_i)
      exu_pkg::CSR_RW: csr_wdata_o = csr_src;
      exu_pkg::CSR_RS: csr_wdata_o = csr_data_i | csr_src;
      exu_pkg::CSR_RC: csr_wdata_o = csr_data_i & ~csr_src;
      default:         csr_wdata_o = csr_data_i;  // unchanged
    endcase
  end

endmodule

//--- source/exu_branch.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_branch (
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic [`EXU_XLEN-1:0] rs1_data_i,
  input  logic [`EXU_XLEN-1:0] rs2_data_i,
  input  logic [`EXU_XLEN-1:0] imm_i,
  input  exu_pkg::exc_op_e     exc_op_i,
  input  exu_pkg::br_cond_e    br_cond_i,
  input  logic                 pdt_taken_i,
  output logic                 is_cf_o,
  output logic                 taken_o,
  output logic                 mispredict_o,
  output logic [`EXU_XLEN-1:0] redirect_pc_o,
  output logic                 misalign_o
);

  logic                 is_br;
  logic                 is_jal;
  logic                 is_jalr;
  logic                 eq;
  logic                 lt_s;
  logic                 lt_u;
  logic                 cond_hit;
  logic [`EXU_XLEN-1:0] tgt_sum;
  logic [`EXU_XLEN-1:0] target;
  logic [`EXU_XLEN-1:0] fall_thru;

  assign is_br   = (exc_op_i == exu_pkg::EXC_BRANCH);
  assign is_jal  = (exc_op_i == exu_pkg::EXC_JAL);
  assign is_jalr = (exc_op_i == exu_pkg::EXC_JALR);

  // own comparator, kept apart from the alu
  assign eq   = (rs1_data_i == rs2_data_i);
  assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign lt_u = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (br_cond_i)
      exu_pkg::BR_EQ:  cond_hit = eq;
      exu_pkg::BR_NE:  cond_hit = ~eq;
      exu_pkg::BR_LT:  cond_hit = lt_s;
      exu_pkg::BR_GE:  cond_hit = ~lt_s;
      exu_pkg::BR_LTU: cond_hit = lt_u;
      exu_pkg::BR_GEU: cond_hit = ~lt_u;
      default:         cond_hit = 1'b0;
    endcase
  end

  assign is_cf_o      = is_br | is_jal | is_jalr;
  assign taken_o      = is_jal | is_jalr | (is_br & cond_hit);  // jumps always taken
  assign mispredict_o = is_cf_o & (taken_o != pdt_taken_i);

  // jalr is register relative and drops bit 0
  assign tgt_sum   = (is_jalr ? rs1_data_i : pc_i) + imm_i;
  assign target    = {tgt_sum[`EXU_XLEN-1:1], tgt_sum[0] & ~is_jalr};
  assign fall_thru = pc_i + `EXU_XLEN'(`EXU_INST_BYTES);

  assign redirect_pc_o = taken_o ? target : fall_thru;

  // taken target must be word aligned
  assign misalign_o = taken_o & target[1];

endmodule

//--- source/exu_commit.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_commit (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   ex_valid_i,
  input  exu_pkg::exc_op_e       exc_op_i,
  input  logic [`EXU_REG_AW-1:0] rd_idx_i,
  input  logic [`EXU_XLEN-1:0]   alu_result_i,
  input  exu_pkg::csr_op_e       csr_op_i,
  input  logic [`EXU_CSR_AW-1:0] csr_addr_i,
  input  logic [`EXU_XLEN-1:0]   csr_wdata_i,
  input  logic                   is_cf_i,
  input  logic                   taken_i,
  input  logic                   mispredict_i,
  input  logic [`EXU_XLEN-1:0]   redirect_pc_i,
  input  logic                   misalign_i,
  output logic                   result_valid_o,
  output logic [`EXU_REG_AW-1:0] rd_idx_o,
  output logic [`EXU_XLEN-1:0]   rd_data_o,
  output logic                   rd_we_o,
  output logic [`EXU_CSR_AW-1:0] csr_addr_o,
  output logic [`EXU_XLEN-1:0]   csr_wdata_o,
  output logic                   csr_we_o,
  output logic                   redirect_valid_o,
  output logic [`EXU_XLEN-1:0]   redirect_pc_o,
  output logic                   bpu_valid_o,
  output logic                   branch_taken_o,
  output logic                   trap_misalign_o
);

  logic writes_rd;
  logic rd_we_d;
  logic csr_we_d;
  logic redirect_d;

  // store, branch and bubbles have no rd
  assign writes_rd = !(exc_op_i inside {exu_pkg::EXC_NONE, exu_pkg::EXC_STORE,
                                        exu_pkg::EXC_BRANCH});
  assign rd_we_d    = writes_rd & (rd_idx_i != '0) & ~misalign_i;  // trap kills link write
  assign csr_we_d   = (exc_op_i == exu_pkg::EXC_CSR) & (csr_op_i != exu_pkg::CSR_NONE);
  assign redirect_d = mispredict_i & ~misalign_i;

  // control bits, low after an empty slot
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      result_valid_o   <= 1'b0;
      rd_we_o          <= 1'b0;
      csr_we_o         <= 1'b0;
      redirect_valid_o <= 1'b0;
      bpu_valid_o      <= 1'b0;
      trap_misalign_o  <= 1'b0;
    end else begin
      result_valid_o   <= ex_valid_i;
      rd_we_o          <= ex_valid_i & rd_we_d;
      csr_we_o         <= ex_valid_i & csr_we_d;
      redirect_valid_o <= ex_valid_i & redirect_d;
      bpu_valid_o      <= ex_valid_i & is_cf_i;
      trap_misalign_o  <= ex_valid_i & misalign_i;
    end
  end

  // payload holds its last value between instructions
  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      rd_idx_o       <= rd_idx_i;
      rd_data_o      <= alu_result_i;
      csr_addr_o     <= csr_addr_i;
      csr_wdata_o    <= csr_wdata_i;
      redirect_pc_o  <= redirect_pc_i;
      branch_taken_o <= taken_i;
    end
  end

endmodule

//--- source/exu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   ex_valid_i,
  input  logic [`EXU_XLEN-1:0]   pc_i,
  input  logic [`EXU_XLEN-1:0]   rs1_data_i,
  input  logic [`EXU_XLEN-1:0]   rs2_data_i,
  input  logic [`EXU_XLEN-1:0]   imm_i,
  input  logic [`EXU_REG_AW-1:0] rd_idx_i,
  input  exu_pkg::exc_op_e       exc_op_i,
  input  exu_pkg::alu_op_e       alu_op_i,
  input  exu_pkg::br_cond_e      br_cond_i,
  input  exu_pkg::csr_op_e       csr_op_i,
  input  logic [`EXU_CSR_AW-1:0] csr_addr_i,
  input  logic [`EXU_XLEN-1:0]   csr_data_i,
  input  logic                   csr_use_imm_i,
  input  logic [`EXU_ZIMM_W-1:0] csr_zimm_i,
  input  logic                   pdt_taken_i,   // predictor direction
  output logic                   result_valid_o,
  output logic [`EXU_REG_AW-1:0] rd_idx_o,
  output logic [`EXU_XLEN-1:0]   rd_data_o,
  output logic                   rd_we_o,
  output logic [`EXU_CSR_AW-1:0] csr_addr_o,
  output logic [`EXU_XLEN-1:0]   csr_wdata_o,
  output logic                   csr_we_o,
  output logic                   redirect_valid_o,
  output logic [`EXU_XLEN-1:0]   redirect_pc_o,
  output logic                   bpu_valid_o,
  output logic                   branch_taken_o,
  output logic                   trap_misalign_o
);

  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic                 is_cf;
  logic                 taken;
  logic                 mispredict;
  logic [`EXU_XLEN-1:0] redirect_pc;
  logic                 misalign;

  // datapath and resolver both see every instruction
  exu_alu u_alu (
    .*,
    .alu_result_o (alu_result),
    .csr_wdata_o  (csr_wdata)
  );

  exu_branch u_branch (
    .*,
    .is_cf_o       (is_cf),
    .taken_o       (taken),
    .mispredict_o  (mispredict),
    .redirect_pc_o (redirect_pc),
    .misalign_o    (misalign)
  );

  // stage register toward mem
  exu_commit u_commit (
    .*,
    .alu_result_i  (alu_result),
    .csr_wdata_i   (csr_wdata),
    .is_cf_i       (is_cf),
    .taken_i       (taken),
    .mispredict_i  (mispredict),
    .redirect_pc_i (redirect_pc),
    .misalign_i    (misalign)
  );

endmodule

//--- sim/exu_props.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_props (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   result_valid_i,
  input logic                   rd_we_i,
  input logic                   csr_we_i,
  input logic                   redirect_valid_i,
  input logic                   bpu_valid_i,
  input logic                   trap_misalign_i,
  input logic [`EXU_REG_AW-1:0] rd_idx_i
);

  // reset clears every control bit of the stage register
  reset_clears_ctrl: assert property (@(posedge clk) !rst_n_i |=> !(result_valid_i | rd_we_i
    | csr_we_i | redirect_valid_i | bpu_valid_i | trap_misalign_i))
    else $error("control output still high one cycle after reset");

  redirect_needs_cf: assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_valid_i |-> bpu_valid_i)
    else $error("redirect raised for an instruction that is no branch or jump");

  no_write_to_x0: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_we_i |-> (rd_idx_i != '0))
    else $error("register write enabled for register zero");

  trap_blocks_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(redirect_valid_i && trap_misalign_i))
    else $error("redirect and misalign trap raised together");

endmodule

bind exu_commit exu_props u_props (
  .clk              (clk),
  .rst_n_i          (rst_n_i),
  .result_valid_i   (result_valid_o),
  .rd_we_i          (rd_we_o),
  .csr_we_i         (csr_we_o),
  .redirect_valid_i (redirect_valid_o),
  .bpu_valid_i      (bpu_valid_o),
  .trap_misalign_i  (trap_misalign_o),
  .rd_idx_i         (rd_idx_o)
);

//--- sim/exu_tb.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;

  localparam int NUM_INSTR      = 2000;
  localparam int TIMEOUT_CYCLES = NUM_INSTR + 200;
  localparam logic [`EXU_XLEN-1:0] SIGN_BIT = {1'b1, {(`EXU_XLEN-1){1'b0}}};

  // expected state of the stage register
  typedef struct packed {
    logic valid, rd_we, csr_we, redir, bpu, trap, known, taken;
    logic [`EXU_REG_AW-1:0] rd_idx;
    logic [`EXU_CSR_AW-1:0] csr_addr;
    logic [`EXU_XLEN-1:0]   rd_data, csr_wdata, redirect_pc;
  } exp_t;

  logic clk = 1'b0, rst_n_i = 1'b0, ex_valid_i = 1'b0, csr_use_imm_i = 1'b0, pdt_taken_i = 1'b0;
  logic [`EXU_XLEN-1:0] pc_i = '0, rs1_data_i = '0, rs2_data_i = '0, imm_i = '0, csr_data_i = '0;
  logic [`EXU_REG_AW-1:0] rd_idx_i = '0;
  logic [`EXU_CSR_AW-1:0] csr_addr_i = '0;
  logic [`EXU_ZIMM_W-1:0] csr_zimm_i = '0;
  exu_pkg::exc_op_e  exc_op_i  = exu_pkg::EXC_NONE;
  exu_pkg::alu_op_e  alu_op_i  = exu_pkg::ALU_ADD;
  exu_pkg::br_cond_e br_cond_i = exu_pkg::BR_EQ;
  exu_pkg::csr_op_e  csr_op_i  = exu_pkg::CSR_NONE;
  logic result_valid_o, rd_we_o, csr_we_o, redirect_valid_o, bpu_valid_o;
  logic branch_taken_o, trap_misalign_o;
  logic [`EXU_REG_AW-1:0] rd_idx_o;
  logic [`EXU_CSR_AW-1:0] csr_addr_o;
  logic [`EXU_XLEN-1:0]   rd_data_o, csr_wdata_o, redirect_pc_o;
  exp_t exp_pending, exp_cur;
  int   seed = 1;
  int   errors = 0, checks = 0;
  logic done = 1'b0, checking = 1'b0;

  exu dut (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // integer function as the ISA defines it
  function automatic logic [`EXU_XLEN-1:0] alu_ref(exu_pkg::alu_op_e fn,
                                                   logic [`EXU_XLEN-1:0] a, b);
    logic [4:0] sh;
    sh = b[4:0];
    case (fn)
      exu_pkg::ALU_ADD:  return a + b;
      exu_pkg::ALU_SUB:  return a - b;
      exu_pkg::ALU_SLL:  return a << sh;
      exu_pkg::ALU_SLT:  return `EXU_XLEN'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));  // biased compare
      exu_pkg::ALU_SLTU: return `EXU_XLEN'(a < b);
      exu_pkg::ALU_XOR:  return a ^ b;
      exu_pkg::ALU_SRL:  return a >> sh;
      exu_pkg::ALU_SRA:  return (a >> sh) | (a[`EXU_XLEN-1] ? ~({`EXU_XLEN{1'b1}} >> sh) : '0);
      exu_pkg::ALU_OR:   return a | b;
      exu_pkg::ALU_AND:  return a & b;
      default:           return '0;
    endcase
  endfunction

  function automatic exp_t predict_stage(exp_t prev, logic vld,
      logic [`EXU_XLEN-1:0] pc, rs1, rs2, imm, logic [`EXU_REG_AW-1:0] rd,
      exu_pkg::exc_op_e cls, exu_pkg::alu_op_e fn, exu_pkg::br_cond_e cond,
      exu_pkg::csr_op_e cop, logic [`EXU_CSR_AW-1:0] caddr, logic [`EXU_XLEN-1:0] cold,
      logic use_imm, logic [`EXU_ZIMM_W-1:0] zimm, logic pdt);
    exp_t                 e;
    logic [`EXU_XLEN-1:0] res;
    logic [`EXU_XLEN-1:0] src;
    logic [`EXU_XLEN-1:0] tgt;
    logic                 hit;
    logic                 cf;
    logic                 tk;
    logic                 bad;
    e        = prev;  // payload holds through bubbles
    e.valid  = vld;
    e.rd_we  = 1'b0;
    e.csr_we = 1'b0;
    e.redir  = 1'b0;
    e.bpu    = 1'b0;
    e.trap   = 1'b0;
    if (vld) begin
      case (cls)
        exu_pkg::EXC_OPREG:                    res = alu_ref(fn, rs1, rs2);
        exu_pkg::EXC_OPIMM:                    res = alu_ref(fn, rs1, imm);
        exu_pkg::EXC_LOAD, exu_pkg::EXC_STORE: res = rs1 + imm;
        exu_pkg::EXC_LUI:                      res = imm;
        exu_pkg::EXC_AUIPC:                    res = pc + imm;
        exu_pkg::EXC_JAL, exu_pkg::EXC_JALR:   res = pc + `EXU_XLEN'(`EXU_INST_BYTES);
        exu_pkg::EXC_CSR:                      res = cold;  // rd gets the old csr
        default:                               res = '0;
      endcase
      case (cond)
        exu_pkg::BR_EQ:  hit = (rs1 == rs2);
        exu_pkg::BR_NE:  hit = (rs1 != rs2);
        exu_pkg::BR_LT:  hit = ((rs1 ^ SIGN_BIT) < (rs2 ^ SIGN_BIT));
        exu_pkg::BR_GE:  hit = ((rs1 ^ SIGN_BIT) >= (rs2 ^ SIGN_BIT));
        exu_pkg::BR_LTU: hit = (rs1 < rs2);
        exu_pkg::BR_GEU: hit = (rs1 >= rs2);
        default:         hit = 1'b0;
      endcase
      cf  = (cls == exu_pkg::EXC_BRANCH) || (cls == exu_pkg::EXC_JAL) || (cls == exu_pkg::EXC_JALR);
      tk  = cf && ((cls != exu_pkg::EXC_BRANCH) || hit);
      tgt = (cls == exu_pkg::EXC_JALR) ? ((rs1 + imm) & ~`EXU_XLEN'(1)) : pc + imm;
      bad = tk && tgt[1];
      src = use_imm ? `EXU_XLEN'(zimm) : rs1;
      case (cop)
        exu_pkg::CSR_RW: e.csr_wdata = src;
        exu_pkg::CSR_RS: e.csr_wdata = cold | src;
        exu_pkg::CSR_RC: e.csr_wdata = cold & ~src;
        default:         e.csr_wdata = cold;
      endcase
      e.rd_we  = (cls != exu_pkg::EXC_NONE) && (cls != exu_pkg::EXC_STORE)
                 && (cls != exu_pkg::EXC_BRANCH) && (rd != '0) && !bad;
      e.csr_we = (cls == exu_pkg::EXC_CSR) && (cop != exu_pkg::CSR_NONE);
      e.redir  = cf && (tk != pdt) && !bad;
      e.bpu    = cf;
      e.trap   = bad;
      e.known  = 1'b1;
      e.taken  = tk;
      e.rd_idx = rd;
      e.rd_data     = res;
      e.csr_addr    = caddr;
      e.redirect_pc = tk ? tgt : pc + `EXU_XLEN'(`EXU_INST_BYTES);
    end
    return e;
  endfunction

  task automatic check_val(string name, logic [`EXU_XLEN-1:0] act, logic [`EXU_XLEN-1:0] expv);
    checks++;
    assert (act === expv) else begin
      $display("[ERROR] %s expected %h actual %h", name, expv, act);
      errors++;
    end
  endtask

  // expected record follows the stage register by one edge
  always @(posedge clk) begin
    exp_cur <= exp_pending;
    if (!rst_n_i) checking <= 1'b1;
  end

  always @(negedge clk) begin
    if (checking) begin
      check_val("result_valid_o", 32'(result_valid_o), 32'(exp_cur.valid));
      check_val("rd_we_o", 32'(rd_we_o), 32'(exp_cur.rd_we));
      check_val("csr_we_o", 32'(csr_we_o), 32'(exp_cur.csr_we));
      check_val("redirect_valid_o", 32'(redirect_valid_o), 32'(exp_cur.redir));
      check_val("bpu_valid_o", 32'(bpu_valid_o), 32'(exp_cur.bpu));
      check_val("trap_misalign_o", 32'(trap_misalign_o), 32'(exp_cur.trap));
      if (exp_cur.known) begin  // payload is undefined before the first instruction
        check_val("rd_idx_o", 32'(rd_idx_o), 32'(exp_cur.rd_idx));
        check_val("rd_data_o", rd_data_o, exp_cur.rd_data);
        check_val("csr_addr_o", 32'(csr_addr_o), 32'(exp_cur.csr_addr));
        check_val("csr_wdata_o", csr_wdata_o, exp_cur.csr_wdata);
        check_val("redirect_pc_o", redirect_pc_o, exp_cur.redirect_pc);
        check_val("branch_taken_o", 32'(branch_taken_o), 32'(exp_cur.taken));
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    int          n;
    int          k;
    exp_pending = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    for (n = 0; n <= NUM_INSTR; n++) begin
      r = $random(seed);
      ex_valid_i    = (r[2:0] != 3'd0) && (n < NUM_INSTR);  // last slot is a bubble
      pdt_taken_i   = r[3];
      csr_use_imm_i = r[4];
      rd_idx_i      = (r[7:5] == 3'd0) ? '0 : r[12:8];
      csr_zimm_i    = r[17:13];
      csr_addr_i    = r[29:18];
      csr_op_i      = exu_pkg::csr_op_e'(r[31:30]);
      exc_op_i      = exu_pkg::exc_op_e'(4'(rand_below(11)));
      alu_op_i      = exu_pkg::alu_op_e'(4'(rand_below(10)));
      k             = rand_below(6);
      br_cond_i     = exu_pkg::br_cond_e'(3'((k < 2) ? k : k + 2));  // codes 2 and 3 unused
      pc_i          = $random(seed) & ~32'h3;
      rs1_data_i    = $random(seed);
      case (rand_below(4))
        0:       rs2_data_i = rs1_data_i;
        1:       rs2_data_i = ~rs1_data_i;  // opposite sign
        default: rs2_data_i = $random(seed);
      endcase
      imm_i = $random(seed);
      if (rand_below(4) != 0) imm_i[1:0] = 2'b00;
      csr_data_i  = $random(seed);
      exp_pending = predict_stage(exp_pending, ex_valid_i, pc_i, rs1_data_i, rs2_data_i, imm_i,
                                  rd_idx_i, exc_op_i, alu_op_i, br_cond_i, csr_op_i, csr_addr_i,
                                  csr_data_i, csr_use_imm_i, csr_zimm_i, pdt_taken_i);
      @(negedge clk);
    end
    @(posedge clk);
    done = 1'b1;
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cyc;
    cyc = 0;
    while (!done && cyc < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    if (!done) begin
      $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+source
source/exu_pkg.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_commit.sv
source/exu.sv
sim/exu_props.sv
sim/exu_tb.sv

//--- Makefile
SRCS := verilog.f $(wildcard source/*.sv source/*.svh sim/*.sv)

all: run

obj_dir/Vexu_tb: $(SRCS)
	verilator --binary --timing --assert --top-module exu_tb -f verilog.f -o Vexu_tb

run: obj_dir/Vexu_tb
	./obj_dir/Vexu_tb > sim.log 2>&1; cat sim.log
	grep -q '^STATUS: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
